// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // instruction and pc width
    localparam int xlen = 32;

    // fetch buffer entries
    localparam int buf_depth = 16;

    // occupancy runs 0 .. buf_depth inclusive
    localparam int cnt_w = $clog2(buf_depth + 1);

    // rom size, kept a power of two so the address wraps on its low bits
    localparam int imem_words = 32;
    localparam int imem_aw = $clog2(imem_words);

    // shared by rom and testbench
    localparam string imem_file = "test/imem.hex";

    typedef logic [xlen-1:0] instr_t;

    // word address
    typedef logic [xlen-1:0] pc_t;

    typedef logic [cnt_w-1:0] cnt_t;

endpackage

// ==== src/fetch_ctrl.sv ====
module fetch_ctrl import fetch_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic redirect,
    input  pc_t  redirect_pc,
    input  logic take_old,
    input  logic take_young,
    input  cnt_t count,
    output pc_t  fetch_pc,
    output logic push,
    output logic two,
    output logic flush
);

    pc_t  pc_q;
    pc_t  pc_step;
    cnt_t n_take;
    cnt_t room_limit;
    logic has_room;

    // entries leaving the buffer at this edge
    assign n_take = cnt_t'(take_old) + cnt_t'(take_young);

    // count - n_take <= buf_depth - 2, moved around so nothing underflows
    assign room_limit = cnt_t'(buf_depth - 2) + n_take;
    assign has_room = (count <= room_limit);

    // even pc starts an aligned pair, odd pc only has its own word
    assign two = ~pc_q[0];

    assign pc_step = two ? pc_t'(2) : pc_t'(1);

    // no fetch in a redirect cycle, the new pc is loaded first
    assign push = rstn & ~redirect & has_room;

    assign flush = redirect;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q <= '0;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (push) begin
            pc_q <= pc_q + pc_step;
        end
    end

    assign fetch_pc = pc_q;

endmodule

// ==== src/imem.sv ====
module imem import fetch_pkg::*; (
    input  pc_t    fetch_pc,
    output instr_t grp_ir0,
    output instr_t grp_ir1
);

    instr_t rom [imem_words];

    logic [imem_aw-1:0] addr0;
    logic [imem_aw-1:0] addr1;

    initial begin
        $readmemh(imem_file, rom);
    end

    // low bits only, so pc and pc+1 both wrap modulo imem_words
    assign addr0 = fetch_pc[imem_aw-1:0];
    assign addr1 = addr0 + 1'b1;

    // combinational read of the fetch group
    assign grp_ir0 = rom[addr0];
    assign grp_ir1 = rom[addr1];

endmodule

// ==== fetch_buffer/fetch_buffer.sv ====
module fetch_buffer import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   flush,
    input  logic   push,
    input  logic   two,
    input  pc_t    fetch_pc,
    input  instr_t grp_ir0,
    input  instr_t grp_ir1,
    input  logic   take_old,
    input  logic   take_young,
    output instr_t ir_old,
    output pc_t    pc_old,
    output instr_t ir_young,
    output pc_t    pc_young,
    output logic   valid_old,
    output logic   valid_young,
    output cnt_t   count
);

    // slot 0 is the oldest entry
    instr_t ir_q [buf_depth];
    pc_t    pc_q [buf_depth];
    cnt_t   count_q;

    instr_t ir_d [buf_depth];
    pc_t    pc_d [buf_depth];
    cnt_t   count_d;

    cnt_t   n_take;
    cnt_t   n_push;
    cnt_t   remaining;
    cnt_t   second_slot;
    pc_t    pc_second;

    assign n_take = cnt_t'(take_old) + cnt_t'(take_young);

    always_comb begin
        if (!push) begin
            n_push = '0;
        end else if (two) begin
            n_push = cnt_t'(2);
        end else begin
            n_push = cnt_t'(1);
        end
    end

    // what is left once the taken entries are gone
    assign remaining = count_q - n_take;
    assign second_slot = remaining + cnt_t'(1);

    // second word of an aligned pair
    assign pc_second = fetch_pc + pc_t'(1);

    // dequeue and enqueue resolved together in one pass
    always_comb begin
        int src;
        src = 0;
        for (int i = 0; i < buf_depth; i++) begin
            src = i + int'(n_take);
            if (src < buf_depth) begin
                ir_d[i] = ir_q[src];
                pc_d[i] = pc_q[src];
            end else begin
                ir_d[i] = ir_q[i];
                pc_d[i] = pc_q[i];
            end

            // new group lands right behind the survivors
            if (push && cnt_t'(i) == remaining) begin
                ir_d[i] = grp_ir0;
                pc_d[i] = fetch_pc;
            end else if (push && two && cnt_t'(i) == second_slot) begin
                ir_d[i] = grp_ir1;
                pc_d[i] = pc_second;
            end
        end
    end

    // a flush drops everything, including this cycle's takes
    assign count_d = flush ? '0 : remaining + n_push;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    // entries past count_q are stale and never shown as valid
    always_ff @(posedge clk) begin
        for (int i = 0; i < buf_depth; i++) begin
            ir_q[i] <= ir_d[i];
            pc_q[i] <= pc_d[i];
        end
    end

    assign ir_old   = ir_q[0];
    assign pc_old   = pc_q[0];
    assign ir_young = ir_q[1];
    assign pc_young = pc_q[1];

    assign valid_old   = (count_q != '0);
    assign valid_young = (count_q > cnt_t'(1));

    assign count = count_q;

endmodule

// ==== src/fetch_top.sv ====
module fetch_top import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   redirect,
    input  pc_t    redirect_pc,
    input  logic   take_old,
    input  logic   take_young,
    output instr_t ir_old,
    output pc_t    pc_old,
    output instr_t ir_young,
    output pc_t    pc_young,
    output logic   valid_old,
    output logic   valid_young
);

    pc_t    fetch_pc;
    logic   push;
    logic   two;
    logic   flush;
    instr_t grp_ir0;
    instr_t grp_ir1;
    cnt_t   count;

    fetch_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .take_old    (take_old),
        .take_young  (take_young),
        .count       (count),
        .fetch_pc    (fetch_pc),
        .push        (push),
        .two         (two),
        .flush       (flush)
    );

    imem u_imem (
        .fetch_pc (fetch_pc),
        .grp_ir0  (grp_ir0),
        .grp_ir1  (grp_ir1)
    );

    fetch_buffer u_buf (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .push        (push),
        .two         (two),
        .fetch_pc    (fetch_pc),
        .grp_ir0     (grp_ir0),
        .grp_ir1     (grp_ir1),
        .take_old    (take_old),
        .take_young  (take_young),
        .ir_old      (ir_old),
        .pc_old      (pc_old),
        .ir_young    (ir_young),
        .pc_young    (pc_young),
        .valid_old   (valid_old),
        .valid_young (valid_young),
        .count       (count)
    );

endmodule

// ==== test/fetch_asserts.sv ====
module fetch_asserts import fetch_pkg::*; (
    input logic clk,
    input logic rstn,
    input logic flush,
    input logic take_old,
    input logic take_young,
    input logic valid_old,
    input logic valid_young,
    input cnt_t count
);

    // bumped by every failing assertion, watched by the testbench
    int fail_count = 0;

    a_count_max: assert property (@(posedge clk) disable iff (!rstn)
        count <= cnt_t'(buf_depth))
        else begin
            fail_count++;
            $error("fetch buffer count above its depth");
        end

    // issue is strictly in order
    a_young_in_order: assert property (@(posedge clk) disable iff (!rstn)
        take_young |-> take_old)
        else begin
            fail_count++;
            $error("young slot taken without the old slot");
        end

    a_take_old_valid: assert property (@(posedge clk) disable iff (!rstn)
        take_old |-> valid_old)
        else begin
            fail_count++;
            $error("old slot taken while not valid");
        end

    a_take_young_valid: assert property (@(posedge clk) disable iff (!rstn)
        take_young |-> valid_young)
        else begin
            fail_count++;
            $error("young slot taken while not valid");
        end

    a_flush_empties: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> (count == '0))
        else begin
            fail_count++;
            $error("buffer not empty after flush");
        end

endmodule

bind fetch_buffer fetch_asserts u_asserts (
    .clk         (clk),
    .rstn        (rstn),
    .flush       (flush),
    .take_old    (take_old),
    .take_young  (take_young),
    .valid_old   (valid_old),
    .valid_young (valid_young),
    .count       (count)
);

// ==== test/tb_fetch.sv ====
module tb_fetch import fetch_pkg::*; ();

    localparam int valid_wait = 50;
    localparam int wrap_wait = 400;

    logic   clk;
    logic   rstn;
    logic   redirect;
    pc_t    redirect_pc;
    logic   take_old;
    logic   take_young;
    instr_t ir_old;
    pc_t    pc_old;
    instr_t ir_young;
    pc_t    pc_young;
    logic   valid_old;
    logic   valid_young;

    instr_t rom_ref [imem_words];
    pc_t    next_pc;
    integer seed;
    string  test_name;

    fetch_top u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .take_old    (take_old),
        .take_young  (take_young),
        .ir_old      (ir_old),
        .pc_old      (pc_old),
        .ir_young    (ir_young),
        .pc_young    (pc_young),
        .valid_old   (valid_old),
        .valid_young (valid_young)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic instr_t expected_ir(pc_t pc);
        return rom_ref[pc % pc_t'(imem_words)];
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pc(string what, pc_t exp, pc_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_ir(string what, instr_t exp, instr_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s %s: expected %h, actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s %s: expected %b, actual %b",
                                test_name, what, exp, act));
        end
    endtask

    // outputs still hold the pre-edge entries here
    always @(posedge clk) begin
        if (!rstn) begin
            next_pc = '0;
        end else if (redirect) begin
            next_pc = redirect_pc;
        end else begin
            if (take_old) begin
                check_pc("old pc", next_pc, pc_old);
                check_ir("old ir", expected_ir(next_pc), ir_old);
                next_pc = next_pc + pc_t'(1);
            end
            if (take_young) begin
                check_pc("young pc", next_pc, pc_young);
                check_ir("young ir", expected_ir(next_pc), ir_young);
                next_pc = next_pc + pc_t'(1);
            end
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_buf.u_asserts.fail_count != 0) begin
            abort_run("a concurrent assertion on the fetch buffer failed");
        end
    end

    task automatic idle_cycle();
        @(negedge clk);
        redirect = 1'b0;
        take_old = 1'b0;
        take_young = 1'b0;
    endtask

    task automatic issue_cycle();
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        redirect = 1'b0;
        take_old = valid_old && (r[1:0] != 2'b00);
        take_young = take_old && valid_young && r[2];
    endtask

    task automatic send_redirect(pc_t target);
        @(negedge clk);
        redirect = 1'b1;
        redirect_pc = target;
        take_old = 1'b0;
        take_young = 1'b0;
        idle_cycle();
    endtask

    task automatic run_issue(int cycles, bit with_redirects);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            r = $random(seed);
            if (with_redirects && r[5:0] == 6'd0) begin
                send_redirect(pc_t'($random(seed)));
            end else begin
                issue_cycle();
            end
        end
    endtask

    task automatic wait_valid_old();
        int waited;
        waited = 0;
        while (!valid_old) begin
            if (waited == valid_wait) begin
                abort_run("timed out waiting for valid_old");
            end
            idle_cycle();
            waited++;
        end
    endtask

    task automatic wait_valid_young();
        int waited;
        waited = 0;
        while (!valid_young) begin
            if (waited == valid_wait) begin
                abort_run("timed out waiting for valid_young");
            end
            idle_cycle();
            waited++;
        end
    endtask

    initial begin
        pc_t target;
        int  waited;
        seed = 32'h1405;
        rstn = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        take_old = 1'b0;
        take_young = 1'b0;
        $readmemh(imem_file, rom_ref);

        test_name = "reset";
        repeat (3) begin
            @(negedge clk);
            check_flag("valid_old", 1'b0, valid_old);
            check_flag("valid_young", 1'b0, valid_young);
        end
        rstn = 1'b1;
        wait_valid_old();
        check_pc("first pc", pc_t'(0), pc_old);
        check_ir("first ir", expected_ir(pc_t'(0)), ir_old);

        test_name = "stream";
        run_issue(300, 1'b1);

        test_name = "backpressure";
        repeat (40) idle_cycle();
        if (u_dut.u_buf.count < cnt_t'(buf_depth - 1)) begin
            abort_run("fetch buffer did not fill while issue was stalled");
        end
        if (u_dut.push) begin
            abort_run("fetch kept pushing into a full buffer");
        end
        run_issue(100, 1'b0);

        test_name = "redirect_even";
        target = pc_t'($random(seed)) & ~pc_t'(1);
        send_redirect(target);
        wait_valid_old();
        check_pc("first pc", target, pc_old);
        check_ir("first ir", expected_ir(target), ir_old);
        // an even target brings a full pair in the first group
        check_flag("first group young valid", 1'b1, valid_young);
        run_issue(60, 1'b0);

        // odd target gives a single word, then aligned pairs
        test_name = "redirect_odd";
        target = pc_t'($random(seed)) | pc_t'(1);
        send_redirect(target);
        wait_valid_old();
        check_pc("first pc", target, pc_old);
        check_ir("first ir", expected_ir(target), ir_old);
        check_flag("first group young valid", 1'b0, valid_young);
        wait_valid_young();
        check_pc("second pc", target + pc_t'(1), pc_young);
        check_ir("second ir", expected_ir(target + pc_t'(1)), ir_young);
        run_issue(60, 1'b0);

        test_name = "rom_wrap";
        target = pc_t'(imem_words - 3);
        send_redirect(target);
        waited = 0;
        while (next_pc < target + pc_t'(3 * imem_words)) begin
            if (waited == wrap_wait) begin
                abort_run("timed out waiting for the fetch stream to pass the rom end");
            end
            issue_cycle();
            waited++;
        end

        test_name = "drain";
        repeat (4) idle_cycle();
        if (u_dut.u_buf.u_asserts.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("a concurrent assertion on the fetch buffer failed");
        end
    end

endmodule

// ==== test/imem.hex ====
// one 32-bit instruction word per line, in hex
// line n holds the word at word address n
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
002081b3
40110233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
4020d533
00112023
00212223
00012583
00412603
00208463
fe209ee3
008000ef
00008067

// ==== sim.f ====
common/fetch_pkg.sv
src/fetch_ctrl.sv
src/imem.sv
fetch_buffer/fetch_buffer.sv
src/fetch_top.sv
test/fetch_asserts.sv
test/tb_fetch.sv
